// File: rtl/core_pkg.sv
// ==========================================================================
// core package: widths, opcodes and ALU operation encoding, the instruction
// word views, fetch buffer entry, micro-op and retire structs, reset PC
// ==========================================================================
package core_pkg;

  localparam int xlen            = 32;
  localparam int line_insts      = 4;
  localparam int line_width      = 128;
  localparam int fb_depth        = 8;
  localparam int fb_ptr_width    = $clog2(fb_depth);
  localparam int fb_count_width  = $clog2(fb_depth + 1);
  localparam int reg_index_width = 5;

  localparam logic [xlen-1:0] reset_pc = '0;

  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef struct packed {
    logic [6:0]                 funct7;
    logic [reg_index_width-1:0] rs2;
    logic [reg_index_width-1:0] rs1;
    logic [2:0]                 funct3;
    logic [reg_index_width-1:0] rd;
    logic [6:0]                 opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0]                imm;
    logic [reg_index_width-1:0] rs1;
    logic [2:0]                 funct3;
    logic [reg_index_width-1:0] rd;
    logic [6:0]                 opcode;
  } i_view_t;

  // one instruction word, read as r-type or i-type
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } inst_word_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    inst_word_t      inst;
  } fb_entry_t;

  typedef struct packed {
    logic                       valid;
    logic [xlen-1:0]            pc;
    alu_op_t                    alu_op;
    logic [reg_index_width-1:0] rs1;
    logic                       rs1_used;
    logic [reg_index_width-1:0] rs2;
    logic                       rs2_used;
    logic [xlen-1:0]            imm;
    logic                       use_imm;
    logic                       lui;
    logic [reg_index_width-1:0] rd;
    logic                       rd_valid;
    logic                       illegal;
  } micro_op_t;

  // rd is zero whenever nothing is written
  typedef struct packed {
    logic                       valid;
    logic [xlen-1:0]            pc;
    logic [reg_index_width-1:0] rd;
    logic [xlen-1:0]            data;
    logic                       illegal;
  } retire_t;

endpackage

// File: rtl/inst_fetch.sv
// ==========================================================================
// instruction fetch: line address register, icache line split into four
// fetch buffer entries, push when the buffer has room for a whole line
// ==========================================================================
`timescale 1ns/100ps

module inst_fetch import core_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [line_width-1:0]      icache_data,
  input  logic                       icache_data_valid,
  input  logic [fb_count_width-1:0]  free_count,
  output logic [xlen-1:0]            icache_addr,
  output fb_entry_t [line_insts-1:0] line,
  output logic                       push
);

  // whole line or nothing
  assign push = icache_data_valid && (free_count >= fb_count_width'(line_insts));

  always_ff @(posedge clock) begin
    if (reset) begin
      icache_addr <= reset_pc;
    end else if (push) begin
      icache_addr <= icache_addr + xlen'(line_insts * 4);
    end
  end

  // lowest word holds the instruction at the line address
  always_comb begin
    for (int i = 0; i < line_insts; i++) begin
      line[i].pc   = icache_addr + xlen'(4 * i);
      line[i].inst = icache_data[xlen*i +: xlen];
    end
  end

  // the buffer never reports more room than its depth
  a_free_count_range: assert property (
    @(posedge clock) disable iff (reset)
    free_count <= fb_count_width'(fb_depth)
  );

endmodule

// File: rtl/fetch_buffer.sv
// ==========================================================================
// fetch buffer: eight entry circular queue, four entries in per push,
// one entry out per pop
// ==========================================================================
`timescale 1ns/100ps

module fetch_buffer import core_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  fb_entry_t [line_insts-1:0] line,
  input  logic                       push,
  input  logic                       pop,
  output fb_entry_t                  head,
  output logic                       head_valid,
  output logic [fb_count_width-1:0]  free_count
);

  fb_entry_t                 mem [fb_depth];
  logic [fb_ptr_width-1:0]   wr_ptr;
  logic [fb_ptr_width-1:0]   rd_ptr;
  logic [fb_count_width-1:0] count;
  logic [fb_count_width-1:0] count_next;

  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign free_count = fb_count_width'(fb_depth) - count;

  always_comb begin
    count_next = count;
    if (push) begin
      count_next = count_next + fb_count_width'(line_insts);
    end
    if (pop) begin
      count_next = count_next - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + fb_ptr_width'(line_insts);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
    end
  end

  // pointer wraps on its own since depth is a power of two
  always_ff @(posedge clock) begin
    if (push) begin
      for (int i = 0; i < line_insts; i++) begin
        mem[wr_ptr + fb_ptr_width'(i)] <= line[i];
      end
    end
  end

  a_no_overflow: assert property (
    @(posedge clock) disable iff (reset)
    push |-> (count <= fb_count_width'(fb_depth - line_insts))
  );

  // decode only pops what it has seen at the head
  a_no_underflow: assert property (
    @(posedge clock) disable iff (reset)
    pop |-> (count != '0)
  );

endmodule

// File: rtl/inst_decode.sv
// ==========================================================================
// instruction decode: OP, OP-IMM and LUI into a micro-op, one register
// stage that holds while issue stalls
// ==========================================================================
`timescale 1ns/100ps

module inst_decode import core_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  fb_entry_t head,
  input  logic      head_valid,
  input  logic      hold,
  output logic      pop,
  output micro_op_t uop
);

  inst_word_t word;
  micro_op_t  dec;
  logic       writes_rd;

  // alt selects sub and sra
  function automatic alu_op_t alu_from_funct3(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign word = head.inst;
  assign pop  = head_valid && !hold;

  always_comb begin
    dec       = '0;
    writes_rd = 1'b0;
    dec.valid = head_valid;
    dec.pc    = head.pc;
    dec.rs1   = word.r.rs1;
    dec.rs2   = word.r.rs2;
    dec.rd    = word.r.rd;
    dec.imm   = {{(xlen-12){word.i.imm[11]}}, word.i.imm};
    case (word.r.opcode)
      opcode_op: begin
        dec.alu_op   = alu_from_funct3(word.r.funct3, word.r.funct7[5]);
        dec.rs1_used = 1'b1;
        dec.rs2_used = 1'b1;
        writes_rd    = 1'b1;
      end
      opcode_op_imm: begin
        dec.alu_op   = alu_from_funct3(word.i.funct3,
                                       (word.i.funct3 == 3'b101) && word.i.imm[10]);
        dec.rs1_used = 1'b1;
        dec.use_imm  = 1'b1;
        writes_rd    = 1'b1;
        // shift amount only
        if (word.i.funct3 == 3'b001 || word.i.funct3 == 3'b101) begin
          dec.imm = {{(xlen-5){1'b0}}, word.i.imm[4:0]};
        end
      end
      opcode_lui: begin
        dec.imm     = {word.i.imm, word.i.rs1, word.i.funct3, 12'b0};
        dec.use_imm = 1'b1;
        dec.lui     = 1'b1;
        writes_rd   = 1'b1;
      end
      default: dec.illegal = 1'b1;
    endcase
    dec.rd_valid = writes_rd && (word.r.rd != '0);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop <= '0;
    end else if (!hold) begin
      uop <= dec;
    end
  end

endmodule

// File: rtl/issue_stage.sv
// ==========================================================================
// issue stage: busy bit scoreboard, hazard hold and operand selection
// for one micro-op per cycle
// ==========================================================================
`timescale 1ns/100ps

module issue_stage import core_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  micro_op_t                  uop,
  input  retire_t                    wb,
  input  logic [xlen-1:0]            rs1_data,
  input  logic [xlen-1:0]            rs2_data,
  output logic [reg_index_width-1:0] rs1_index,
  output logic [reg_index_width-1:0] rs2_index,
  output logic                       hold,
  output micro_op_t                  issued,
  output logic [xlen-1:0]            op_a,
  output logic [xlen-1:0]            op_b
);

  logic [2**reg_index_width-1:0] busy;
  logic                          rs1_busy;
  logic                          rs2_busy;
  logic                          take;
  logic                          wb_write;

  assign rs1_index = uop.rs1;
  assign rs2_index = uop.rs2;

  // x0 never waits
  assign rs1_busy = uop.rs1_used && (uop.rs1 != '0) && busy[uop.rs1];
  assign rs2_busy = uop.rs2_used && (uop.rs2 != '0) && busy[uop.rs2];

  assign hold     = uop.valid && (rs1_busy || rs2_busy);
  assign take     = uop.valid && !hold;
  assign wb_write = wb.valid && (wb.rd != '0);

  always_comb begin
    issued       = uop;
    issued.valid = take;
  end

  assign op_a = uop.lui ? '0 : rs1_data;
  assign op_b = uop.use_imm ? uop.imm : rs2_data;

  // a new producer wins over a write-back to the same register
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wb_write) begin
        busy[wb.rd] <= 1'b0;
      end
      if (take && uop.rd_valid) begin
        busy[uop.rd] <= 1'b1;
      end
    end
  end

  a_x0_never_busy: assert property (
    @(posedge clock) disable iff (reset)
    !busy[0]
  );

  // every write-back belongs to a register marked at issue
  a_wb_was_busy: assert property (
    @(posedge clock) disable iff (reset)
    wb_write |-> busy[wb.rd]
  );

endmodule

// File: rtl/int_regfile.sv
// ==========================================================================
// integer register file: 32 x 32, two combinational read ports,
// one write port from write-back, x0 reads zero
// ==========================================================================
`timescale 1ns/100ps

module int_regfile import core_pkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [reg_index_width-1:0] rs1_index,
  input  logic [reg_index_width-1:0] rs2_index,
  input  retire_t                    wb,
  output logic [xlen-1:0]            rs1_data,
  output logic [xlen-1:0]            rs2_data
);

  logic [xlen-1:0] regs [2**reg_index_width];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_index_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1_data = (rs1_index == '0) ? '0 : regs[rs1_index];
  assign rs2_data = (rs2_index == '0) ? '0 : regs[rs2_index];

endmodule

// File: rtl/alu_pipe.sv
// ==========================================================================
// ALU pipe: RV32I integer operations and the write-back register that
// feeds the register file, the scoreboard and the retire port
// ==========================================================================
`timescale 1ns/100ps

module alu_pipe import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  micro_op_t       issued,
  input  logic [xlen-1:0] op_a,
  input  logic [xlen-1:0] op_b,
  output retire_t         wb
);

  logic [xlen-1:0] result;
  logic [4:0]      shamt;

  assign shamt = op_b[4:0];

  always_comb begin
    case (issued.alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_sll:  result = op_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      default:  result = '0;
    endcase
  end

  // x0 writes and illegal ops retire with zero data
  always_ff @(posedge clock) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.valid   <= issued.valid;
      wb.pc      <= issued.pc;
      wb.rd      <= issued.rd_valid ? issued.rd : '0;
      wb.data    <= issued.rd_valid ? result : '0;
      wb.illegal <= issued.illegal;
    end
  end

endmodule

// File: rtl/core.sv
// ==========================================================================
// core top level: fetch, fetch buffer, decode, issue, register file and
// ALU pipe, with write-back driving the retire port
// ==========================================================================
`timescale 1ns/100ps

module core import core_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [line_width-1:0] icache_data,
  input  logic                  icache_data_valid,
  output logic [xlen-1:0]       icache_addr,
  output retire_t               retire
);

  fb_entry_t [line_insts-1:0] fb_line;
  logic                       fb_push;
  logic [fb_count_width-1:0]  free_count;
  fb_entry_t                  fb_head;
  logic                       fb_head_valid;
  logic                       fb_pop;
  micro_op_t                  dec_uop;
  logic                       hold;
  logic [reg_index_width-1:0] rs1_index;
  logic [reg_index_width-1:0] rs2_index;
  logic [xlen-1:0]            rs1_data;
  logic [xlen-1:0]            rs2_data;
  micro_op_t                  issued;
  logic [xlen-1:0]            op_a;
  logic [xlen-1:0]            op_b;
  retire_t                    wb;

  inst_fetch fetch_inst (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .free_count        (free_count),
    .icache_addr       (icache_addr),
    .line              (fb_line),
    .push              (fb_push)
  );

  fetch_buffer fb_inst (
    .clock      (clock),
    .reset      (reset),
    .line       (fb_line),
    .push       (fb_push),
    .pop        (fb_pop),
    .head       (fb_head),
    .head_valid (fb_head_valid),
    .free_count (free_count)
  );

  inst_decode decode_inst (
    .clock      (clock),
    .reset      (reset),
    .head       (fb_head),
    .head_valid (fb_head_valid),
    .hold       (hold),
    .pop        (fb_pop),
    .uop        (dec_uop)
  );

  issue_stage issue_inst (
    .clock     (clock),
    .reset     (reset),
    .uop       (dec_uop),
    .wb        (wb),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .hold      (hold),
    .issued    (issued),
    .op_a      (op_a),
    .op_b      (op_b)
  );

  int_regfile regfile_inst (
    .clock     (clock),
    .reset     (reset),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .wb        (wb),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  alu_pipe alu_inst (
    .clock  (clock),
    .reset  (reset),
    .issued (issued),
    .op_a   (op_a),
    .op_b   (op_b),
    .wb     (wb)
  );

  // write-back is the retire port
  assign retire = wb;

endmodule

// File: tests/core_tb.sv
// ==========================================================================
// core testbench: icache model with optional random delay, ISA reference
// model, retire monitor and directed tests
// ==========================================================================
`timescale 1ns/100ps

module core_tb import core_pkg::*; ();

  localparam logic [31:0] filler_inst     = 32'h00000013;
  localparam int          cycles_per_inst = 40;

  logic                  clock             = 1'b0;
  logic                  reset             = 1'b1;
  logic [line_width-1:0] icache_data       = '0;
  logic                  icache_data_valid = 1'b0;
  logic [xlen-1:0]       icache_addr;
  retire_t               retire;

  logic [31:0] prog [64];
  logic [31:0] model_regs [32];
  retire_t     expected [$];
  retire_t     exp_entry;
  int          prog_len        = 0;
  string       test_name       = "none";
  bit          random_mode     = 1'b0;
  bit          checking        = 1'b0;
  int          retired_count   = 0;
  int          mismatch_errors = 0;
  int          other_errors    = 0;
  int          cycle_count     = 0;
  int          cycle_limit     = 0;
  logic [31:0] lcg_state       = 32'h66e;
  logic [31:0] last_addr       = '1;
  int          delay_left      = 0;

  always #4 clock = ~clock;

  core core_inst (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .icache_addr       (icache_addr),
    .retire            (retire)
  );

  function automatic logic [1:0] next_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:30];
  endfunction

  // past the program the icache returns addi x0, x0, 0
  function automatic logic [31:0] fetch_word(input logic [xlen-1:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len) begin
      return prog[idx];
    end
    return filler_inst;
  endfunction

  function automatic logic [31:0] r_inst(input int funct7, input int funct3, input int rd,
                                         input int rs1, input int rs2);
    return {7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), opcode_op};
  endfunction

  function automatic logic [31:0] i_inst(input int funct3, input int rd, input int rs1,
                                         input int imm);
    return {12'(imm), 5'(rs1), 3'(funct3), 5'(rd), opcode_op_imm};
  endfunction

  function automatic logic [31:0] lui_inst(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), opcode_lui};
  endfunction

  // RV32I integer result, alt is instruction bit 30
  function automatic logic [31:0] isa_result(input logic [2:0] funct3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (funct3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic add_inst(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  // runs the program on zeroed model registers
  task automatic build_expected();
    logic [31:0] w;
    logic [31:0] value;
    logic [31:0] imm;
    logic        writes;
    retire_t     entry;
    expected.delete();
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < prog_len; i++) begin
      w      = prog[i];
      imm    = {{20{w[31]}}, w[31:20]};
      value  = '0;
      writes = 1'b1;
      entry  = '0;
      case (w[6:0])
        opcode_op:     value = isa_result(w[14:12], w[30], model_regs[w[19:15]],
                                          model_regs[w[24:20]]);
        opcode_op_imm: value = isa_result(w[14:12], (w[14:12] == 3'b101) && w[30],
                                          model_regs[w[19:15]], imm);
        opcode_lui:    value = {w[31:12], 12'h000};
        default: begin
          writes        = 1'b0;
          entry.illegal = 1'b1;
        end
      endcase
      entry.valid = 1'b1;
      entry.pc    = 32'(i * 4);
      if (writes && w[11:7] != 5'd0) begin
        model_regs[w[11:7]] = value;
        entry.rd            = w[11:7];
        entry.data          = value;
      end
      expected.push_back(entry);
    end
  endtask

  // icache model, a new line address starts a new delay
  always @(posedge clock) begin
    #1;
    if (icache_addr !== last_addr) begin
      last_addr  = icache_addr;
      delay_left = random_mode ? int'(next_delay()) : 0;
    end else if (delay_left != 0) begin
      delay_left--;
    end
    icache_data_valid = (delay_left == 0);
    for (int i = 0; i < line_insts; i++) begin
      icache_data[32*i +: 32] = fetch_word(icache_addr + 32'(4 * i));
    end
  end

  // retire monitor, filler retires are skipped
  always @(negedge clock) begin
    if (!reset && checking && retire.valid && retire.pc < 32'(prog_len * 4)) begin
      if (retired_count >= expected.size()) begin
        other_errors++;
        $display("%s: retire at pc %h with no instruction left to retire",
                 test_name, retire.pc);
      end else begin
        exp_entry = expected[retired_count];
        if (retire !== exp_entry) begin
          mismatch_errors++;
          $display("Mismatch %s: retire %0d expected pc=%h rd=%0d data=%h illegal=%b, %s",
                   test_name, retired_count, exp_entry.pc, exp_entry.rd, exp_entry.data,
                   exp_entry.illegal,
                   $sformatf("actual pc=%h rd=%0d data=%h illegal=%b",
                             retire.pc, retire.rd, retire.data, retire.illegal));
        end
      end
      retired_count++;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout in %s: only %0d of %0d instructions retired after %0d cycles",
               test_name, retired_count, expected.size(), cycle_count);
      $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors + 1);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic apply_reset();
    @(posedge clock);
    #1;
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #1;
    if (icache_addr !== reset_pc) begin
      other_errors++;
      $display("%s: icache_addr is %h under reset, not the reset pc", test_name, icache_addr);
    end
    if (retire.valid !== 1'b0) begin
      other_errors++;
      $display("%s: retire valid is not low under reset", test_name);
    end
    reset = 1'b0;
  endtask

  // stop_after of zero runs the whole program
  task automatic run_program(input string name, input bit rand_mode, input int stop_after);
    int target;
    test_name   = name;
    random_mode = rand_mode;
    checking    = 1'b0;
    cycle_limit = cycle_limit + cycles_per_inst * prog_len;
    apply_reset();
    build_expected();
    retired_count = 0;
    checking      = 1'b1;
    target        = (stop_after > 0) ? stop_after : expected.size();
    wait (retired_count >= target);
    checking = 1'b0;
  endtask

  task automatic alu_mix_program();
    prog_len = 0;
    add_inst(lui_inst(1, 'hfffff));
    add_inst(i_inst(0, 2, 0, -7));
    add_inst(i_inst(0, 3, 0, 'h123));
    add_inst(i_inst(6, 5, 0, -256));
    add_inst(i_inst(4, 6, 0, 'h55));
    add_inst(i_inst(2, 7, 0, -1));
    add_inst(i_inst(3, 8, 0, -1));
    add_inst(lui_inst(9, 'h12345));
    add_inst(r_inst(32, 0, 10, 3, 2));
    add_inst(r_inst(32, 5, 11, 1, 3));
    add_inst(r_inst(0, 3, 12, 2, 3));
    add_inst(r_inst(0, 2, 13, 2, 3));
    add_inst(i_inst(5, 14, 9, 'h404));
    add_inst(i_inst(1, 15, 3, 7));
    add_inst(i_inst(5, 16, 1, 8));
    add_inst(r_inst(0, 7, 17, 1, 3));
    add_inst(r_inst(0, 6, 18, 2, 9));
    add_inst(r_inst(0, 4, 19, 5, 9));
    add_inst(r_inst(0, 1, 20, 9, 3));
    add_inst(r_inst(0, 5, 21, 1, 3));
    add_inst(r_inst(0, 0, 22, 2, 9));
  endtask

  // each instruction reads the rd of the one before
  task automatic chain_program();
    prog_len = 0;
    add_inst(i_inst(0, 1, 0, 3));
    add_inst(r_inst(0, 0, 2, 1, 1));
    add_inst(r_inst(32, 0, 3, 0, 2));
    add_inst(r_inst(32, 5, 4, 3, 1));
    add_inst(i_inst(4, 5, 4, 'h7f));
    add_inst(i_inst(5, 6, 5, 'h402));
    add_inst(r_inst(0, 0, 6, 6, 6));
    add_inst(r_inst(0, 2, 7, 6, 0));
    add_inst(r_inst(0, 1, 8, 1, 7));
    add_inst(i_inst(7, 9, 8, 5));
    add_inst(r_inst(0, 6, 10, 9, 3));
  endtask

  task automatic x0_program();
    prog_len = 0;
    add_inst(i_inst(0, 1, 0, 9));
    add_inst(i_inst(0, 0, 1, 5));
    add_inst(r_inst(0, 0, 2, 0, 1));
    add_inst(lui_inst(0, 1));
    // lw x2, 0(x1) is not supported
    add_inst(32'h0000a103);
    add_inst(i_inst(0, 3, 2, 1));
    add_inst(32'hffffffff);
    add_inst(r_inst(32, 0, 4, 2, 0));
    add_inst(r_inst(0, 2, 5, 0, 0));
  endtask

  task automatic independent_ops();
    alu_mix_program();
    run_program("independent_ops", 1'b0, 0);
  endtask

  task automatic dependent_chain();
    chain_program();
    run_program("dependent_chain", 1'b0, 0);
  endtask

  task automatic random_icache_delay();
    alu_mix_program();
    run_program("random_delay_alu_mix", 1'b1, 0);
    chain_program();
    run_program("random_delay_chain", 1'b1, 0);
    x0_program();
    run_program("random_delay_x0", 1'b1, 0);
  endtask

  task automatic x0_and_illegal();
    x0_program();
    run_program("x0_and_illegal", 1'b0, 0);
  endtask

  // the rerun starts with a reset while the first run is still in flight
  task automatic reset_midway();
    chain_program();
    run_program("reset_midway", 1'b0, 4);
    run_program("reset_rerun", 1'b0, 0);
  endtask

  initial begin
    independent_ops();
    dependent_chain();
    random_icache_delay();
    x0_and_illegal();
    reset_midway();
    $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
rtl/core_pkg.sv
rtl/inst_fetch.sv
rtl/fetch_buffer.sv
rtl/inst_decode.sv
rtl/issue_stage.sv
rtl/int_regfile.sv
rtl/alu_pipe.sv
rtl/core.sv
tests/core_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = core_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
